//--- common/pma_pkg.sv
// shared PMA types and constants; 34-bit PA, 8 entries, OFF/NAPOT modes only, fixed default map
`default_nettype none

package pma_pkg;

    localparam int PALEN           = 34;
    localparam int PMA_ENTRIES     = 8;
    localparam int DEFAULT_REGIONS = 4;

    typedef logic [PALEN-1:0] pa_t;
    typedef logic [31:0]      pma_addr_t;   // holds PA[33:2]
    typedef logic [3:0]       mtype_t;
    typedef logic [1:0]       priv_t;
    typedef logic [11:0]      csr_addr_t;
    typedef logic [31:0]      csr_data_t;

    localparam mtype_t MTYPE_DEV     = 4'd0;
    localparam mtype_t MTYPE_DEV_BUF = 4'd1;
    localparam mtype_t MTYPE_MEM_NC  = 4'd2;
    localparam mtype_t MTYPE_MEM_WT  = 4'd4;
    localparam mtype_t MTYPE_MEM_WB  = 4'd6;
    localparam mtype_t MTYPE_EMPTY   = 4'd15;  // hole, any access faults

    localparam priv_t PRIV_M = 2'd3;

    localparam logic [1:0] MODE_OFF   = 2'd0;
    localparam logic [1:0] MODE_NAPOT = 2'd3;

    typedef struct packed {
        logic       rsvd;
        logic       namo;
        mtype_t     mtype;
        logic [1:0] mode;
    } pma_cfg_t;

    localparam csr_addr_t CSR_PMACFG0  = 12'hBC0;  // entries 0..3, entry 0 in the low byte
    localparam csr_addr_t CSR_PMACFG1  = 12'hBC1;  // entries 4..7
    localparam csr_addr_t CSR_PMAADDR0 = 12'hBD0;  // entries 0..7 at BD0..BD7

    // a zero mask disables a region
    localparam pa_t DEV_BASE [DEFAULT_REGIONS] = '{
        34'h0_8000_0000, 34'h3_FFFF_FFFF, 34'h3_FFFF_FFFF, 34'h3_FFFF_FFFF
    };
    localparam pa_t DEV_MASK [DEFAULT_REGIONS] = '{
        34'h0_8000_0000, 34'h0_0000_0000, 34'h0_0000_0000, 34'h0_0000_0000
    };
    localparam pa_t WT_BASE [DEFAULT_REGIONS] = '{
        34'h0_4000_0000, 34'h3_FFFF_FFFF, 34'h3_FFFF_FFFF, 34'h3_FFFF_FFFF
    };
    localparam pa_t WT_MASK [DEFAULT_REGIONS] = '{
        34'h0_C000_0000, 34'h0_0000_0000, 34'h0_0000_0000, 34'h0_0000_0000
    };

    typedef struct packed {
        logic valid;
        pa_t  pa;
    } pma_req_t;

    typedef struct packed {
        logic   valid;
        logic   fault;
        mtype_t mtype;
        logic   namo;
    } pma_resp_t;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        csr_data_t data;
    } csr_wr_t;

endpackage

`default_nettype wire

//--- pma_checker/pma_entry_match.sv
// NAPOT match of one PA against one entry; k trailing ones in addr give a 2^(k+3) byte block
`timescale 1ns/1ps
`default_nettype none

module pma_entry_match (
    input  pma_pkg::pa_t       pa,
    input  pma_pkg::pma_cfg_t  cfg,
    input  pma_pkg::pma_addr_t addr,
    output logic               match
);

    pma_pkg::pma_addr_t pa_word;
    pma_pkg::pma_addr_t care;

    assign pa_word = pa[pma_pkg::PALEN-1:2];

    // trailing ones plus the first zero are don't-care, all ones leaves nothing to compare
    assign care = ~(addr ^ (addr + pma_pkg::pma_addr_t'(1)));

    assign match = (cfg.mode == pma_pkg::MODE_NAPOT) && (((pa_word ^ addr) & care) == '0);

endmodule

`default_nettype wire

//--- pma_checker/pma_default_map.sv
// fixed fallback map for unmatched PAs; device regions beat write-through, the rest is write-back
`timescale 1ns/1ps
`default_nettype none

module pma_default_map (
    input  pma_pkg::pa_t    pa,
    output pma_pkg::mtype_t mtype,
    output logic            namo
);

    logic [pma_pkg::DEFAULT_REGIONS-1:0] dev_hit;
    logic [pma_pkg::DEFAULT_REGIONS-1:0] wt_hit;

    always_comb begin
        for (int i = 0; i < pma_pkg::DEFAULT_REGIONS; i++) begin
            dev_hit[i] = (pma_pkg::DEV_MASK[i] != '0) &&
                         (((pa ^ pma_pkg::DEV_BASE[i]) & pma_pkg::DEV_MASK[i]) == '0);
            wt_hit[i]  = (pma_pkg::WT_MASK[i] != '0) &&
                         (((pa ^ pma_pkg::WT_BASE[i]) & pma_pkg::WT_MASK[i]) == '0);
        end
    end

    always_comb begin
        if (|dev_hit) begin
            mtype = pma_pkg::MTYPE_DEV;
            namo  = 1'b1;  // no atomics on device space
        end else if (|wt_hit) begin
            mtype = pma_pkg::MTYPE_MEM_WT;
            namo  = 1'b0;
        end else begin
            mtype = pma_pkg::MTYPE_MEM_WB;
            namo  = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- pma_checker/pma_checker.sv
// one requester's PMA lookup; lowest-numbered matching entry wins, result registered for one cycle
`timescale 1ns/1ps
`default_nettype none

module pma_checker (
    input  wire                                           core_clk,
    input  wire                                           core_reset,
    input  pma_pkg::pma_req_t                             req,
    input  pma_pkg::pma_cfg_t  [pma_pkg::PMA_ENTRIES-1:0] entry_cfg,
    input  pma_pkg::pma_addr_t [pma_pkg::PMA_ENTRIES-1:0] entry_addr,
    output pma_pkg::pma_resp_t                            resp
);

    logic [pma_pkg::PMA_ENTRIES-1:0] entry_hit;
    pma_pkg::mtype_t                 dflt_mtype;
    logic                            dflt_namo;
    pma_pkg::mtype_t                 sel_mtype;
    logic                            sel_namo;
    logic                            sel_fault;

    for (genvar i = 0; i < pma_pkg::PMA_ENTRIES; i++) begin : g_entry
        pma_entry_match u_pma_entry_match (
            .pa    (req.pa),
            .cfg   (entry_cfg[i]),
            .addr  (entry_addr[i]),
            .match (entry_hit[i])
        );
    end

    pma_default_map u_pma_default_map (
        .pa    (req.pa),
        .mtype (dflt_mtype),
        .namo  (dflt_namo)
    );

    // walk from the top entry down so the lowest match is the one that sticks
    always_comb begin
        sel_mtype = dflt_mtype;
        sel_namo  = dflt_namo;
        for (int i = pma_pkg::PMA_ENTRIES - 1; i >= 0; i--) begin
            if (entry_hit[i]) begin
                sel_mtype = entry_cfg[i].mtype;
                sel_namo  = entry_cfg[i].namo;
            end
        end
    end

    assign sel_fault = (sel_mtype == pma_pkg::MTYPE_EMPTY);

    // one result in flight, a new request may land every cycle
    always_ff @(posedge core_clk) begin
        if (core_reset) begin
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= req.valid;
        end
        if (req.valid) begin
            resp.fault <= sel_fault;
            resp.mtype <= sel_mtype;
            resp.namo  <= sel_namo;
        end
    end

endmodule

`default_nettype wire

//--- source/pma_csr.sv
// PMA entry registers; writes need machine mode, cfg writes are WARL, reads are combinational
`timescale 1ns/1ps
`default_nettype none

module pma_csr (
    input  wire                                                 core_clk,
    input  wire                                                 core_reset,
    input  pma_pkg::priv_t                                      csr_cur_privilege,
    input  pma_pkg::csr_wr_t                                    csr_wr,
    input  pma_pkg::csr_addr_t                                  csr_raddr0,
    input  pma_pkg::csr_addr_t                                  csr_raddr1,
    output logic                                                csr_hit0,
    output logic                                                csr_hit1,
    output pma_pkg::csr_data_t                                  csr_rdata0,
    output pma_pkg::csr_data_t                                  csr_rdata1,
    output pma_pkg::pma_cfg_t  [pma_pkg::PMA_ENTRIES-1:0]       entry_cfg,
    output pma_pkg::pma_addr_t [pma_pkg::PMA_ENTRIES-1:0]       entry_addr
);

    logic wr_ok;

    // only OFF and NAPOT are legal, the reserved bit is tied low
    function automatic pma_pkg::pma_cfg_t cfg_warl(input logic [7:0] wbyte);
        pma_pkg::pma_cfg_t cfg;
        cfg      = pma_pkg::pma_cfg_t'(wbyte);
        cfg.rsvd = 1'b0;
        if (cfg.mode != pma_pkg::MODE_NAPOT) begin
            cfg.mode = pma_pkg::MODE_OFF;
        end
        return cfg;
    endfunction

    function automatic void csr_read(
        input  pma_pkg::csr_addr_t raddr,
        output logic               hit,
        output pma_pkg::csr_data_t rdata
    );
        hit   = 1'b0;
        rdata = '0;
        for (int i = 0; i < pma_pkg::PMA_ENTRIES / 4; i++) begin
            if (raddr == pma_pkg::csr_addr_t'(pma_pkg::CSR_PMACFG0 + i)) begin
                hit   = 1'b1;
                rdata = entry_cfg[4 * i + 3 -: 4];  // four cfg bytes per CSR
            end
        end
        for (int i = 0; i < pma_pkg::PMA_ENTRIES; i++) begin
            if (raddr == pma_pkg::csr_addr_t'(pma_pkg::CSR_PMAADDR0 + i)) begin
                hit   = 1'b1;
                rdata = entry_addr[i];
            end
        end
    endfunction

    assign wr_ok = csr_wr.we && (csr_cur_privilege == pma_pkg::PRIV_M);

    always_ff @(posedge core_clk) begin
        if (core_reset) begin
            entry_cfg  <= '0;  // all entries off, lookups fall back to the default map
            entry_addr <= '0;
        end else if (wr_ok) begin
            for (int i = 0; i < pma_pkg::PMA_ENTRIES; i++) begin
                if (csr_wr.addr == pma_pkg::csr_addr_t'(pma_pkg::CSR_PMACFG0 + i / 4)) begin
                    entry_cfg[i] <= cfg_warl(csr_wr.data[8 * (i % 4) +: 8]);
                end
                if (csr_wr.addr == pma_pkg::csr_addr_t'(pma_pkg::CSR_PMAADDR0 + i)) begin
                    entry_addr[i] <= csr_wr.data;
                end
            end
        end
    end

    always_comb begin
        csr_read(csr_raddr0, csr_hit0, csr_rdata0);
    end

    always_comb begin
        csr_read(csr_raddr1, csr_hit1, csr_rdata1);
    end

endmodule

`default_nettype wire

//--- source/pma_unit.sv
// PMA unit top; one-cycle lookup per port with no back-pressure, fetch side never reports namo
`timescale 1ns/1ps
`default_nettype none

module pma_unit (
    input  wire                core_clk,
    input  wire                core_reset,
    input  pma_pkg::priv_t     csr_cur_privilege,
    input  pma_pkg::csr_wr_t   csr_wr,
    input  pma_pkg::csr_addr_t csr_raddr0,
    input  pma_pkg::csr_addr_t csr_raddr1,
    output logic               csr_hit0,
    output logic               csr_hit1,
    output pma_pkg::csr_data_t csr_rdata0,
    output pma_pkg::csr_data_t csr_rdata1,
    input  pma_pkg::pma_req_t  ifu_req,
    input  pma_pkg::pma_req_t  lsu_req,
    output pma_pkg::pma_resp_t ifu_resp,
    output pma_pkg::pma_resp_t lsu_resp
);

    pma_pkg::pma_cfg_t  [pma_pkg::PMA_ENTRIES-1:0] entry_cfg;
    pma_pkg::pma_addr_t [pma_pkg::PMA_ENTRIES-1:0] entry_addr;
    pma_pkg::pma_resp_t                            ifu_check_resp;

    pma_csr u_pma_csr (
        .core_clk          (core_clk),
        .core_reset        (core_reset),
        .csr_cur_privilege (csr_cur_privilege),
        .csr_wr            (csr_wr),
        .csr_raddr0        (csr_raddr0),
        .csr_raddr1        (csr_raddr1),
        .csr_hit0          (csr_hit0),
        .csr_hit1          (csr_hit1),
        .csr_rdata0        (csr_rdata0),
        .csr_rdata1        (csr_rdata1),
        .entry_cfg         (entry_cfg),
        .entry_addr        (entry_addr)
    );

    pma_checker u_pma_checker_ifu (
        .core_clk   (core_clk),
        .core_reset (core_reset),
        .req        (ifu_req),
        .entry_cfg  (entry_cfg),
        .entry_addr (entry_addr),
        .resp       (ifu_check_resp)
    );

    pma_checker u_pma_checker_lsu (
        .core_clk   (core_clk),
        .core_reset (core_reset),
        .req        (lsu_req),
        .entry_cfg  (entry_cfg),
        .entry_addr (entry_addr),
        .resp       (lsu_resp)
    );

    assign ifu_resp.valid = ifu_check_resp.valid;
    assign ifu_resp.fault = ifu_check_resp.fault;
    assign ifu_resp.mtype = ifu_check_resp.mtype;
    assign ifu_resp.namo  = 1'b0;  // fetch has no atomics

endmodule

`default_nettype wire

//--- sim/pma_unit_tb.sv
// testbench for pma_unit; plays sim/pma_vectors.txt from the project root, then random lsu traffic
`timescale 1ns/1ps
`default_nettype none

module pma_unit_tb;

    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 5;
    localparam int    RAND_COUNT   = 64;
    localparam string VEC_FILE     = "sim/pma_vectors.txt";

    logic               core_clk;
    logic               core_reset;
    pma_pkg::priv_t     csr_cur_privilege;
    pma_pkg::csr_wr_t   csr_wr;
    pma_pkg::csr_addr_t csr_raddr0;
    pma_pkg::csr_addr_t csr_raddr1;
    logic               csr_hit0;
    logic               csr_hit1;
    pma_pkg::csr_data_t csr_rdata0;
    pma_pkg::csr_data_t csr_rdata1;
    pma_pkg::pma_req_t  ifu_req;
    pma_pkg::pma_req_t  lsu_req;
    pma_pkg::pma_resp_t ifu_resp;
    pma_pkg::pma_resp_t lsu_resp;

    string            vec_lines [$];
    logic [7:0]       shadow_cfg [pma_pkg::PMA_ENTRIES];
    logic [31:0]      shadow_addr [pma_pkg::PMA_ENTRIES];
    pma_pkg::pa_t     rand_pa [RAND_COUNT];
    logic [31:0]      rng_state;
    logic [8*32-1:0]  test_name;
    logic             test_open;
    logic             loaded;
    logic             load_ok;
    int               test_checks;
    int               test_errs;
    int               total_errs;
    int               tests_passed;
    int               tests_failed;

    pma_unit u_pma_unit (
        .core_clk          (core_clk),
        .core_reset        (core_reset),
        .csr_cur_privilege (csr_cur_privilege),
        .csr_wr            (csr_wr),
        .csr_raddr0        (csr_raddr0),
        .csr_raddr1        (csr_raddr1),
        .csr_hit0          (csr_hit0),
        .csr_hit1          (csr_hit1),
        .csr_rdata0        (csr_rdata0),
        .csr_rdata1        (csr_rdata1),
        .ifu_req           (ifu_req),
        .lsu_req           (lsu_req),
        .ifu_resp          (ifu_resp),
        .lsu_resp          (lsu_resp)
    );

    initial begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    // budget of four clock periods per vector line, random request and reset cycle
    initial begin
        int limit_ns;
        wait (loaded);
        limit_ns = (vec_lines.size() + RAND_COUNT + RESET_CYCLES) * 4 * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog expired after %0d ns, the run stalled", limit_ns);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // k trailing ones in the entry address give a block of 2^(k+3) bytes
    function automatic logic napot_hit(input pma_pkg::pa_t pa, input logic [7:0] cfg,
                                       input logic [31:0] addr);
        logic [31:0] ones;
        int          k;
        ones = addr;
        k    = 0;
        if (cfg[1:0] != 2'd3) begin
            return 1'b0;
        end
        while (ones[0]) begin
            k++;
            ones = ones >> 1;
        end
        if (k == 32) begin
            return 1'b1;
        end
        return (pa >> (k + 3)) == ({addr, 2'b00} >> (k + 3));
    endfunction

    task automatic model_lookup(input pma_pkg::pa_t pa, output logic fault,
                                output logic [3:0] mtype, output logic namo);
        logic found;
        found = 1'b0;
        if (pa[31]) begin
            mtype = 4'h0;  // device region
            namo  = 1'b1;
        end else if (pa[31:30] == 2'b01) begin
            mtype = 4'h4;
            namo  = 1'b0;
        end else begin
            mtype = 4'h6;
            namo  = 1'b0;
        end
        for (int i = 0; i < pma_pkg::PMA_ENTRIES; i++) begin
            if (!found && napot_hit(pa, shadow_cfg[i], shadow_addr[i])) begin
                found = 1'b1;
                mtype = shadow_cfg[i][5:2];
                namo  = shadow_cfg[i][6];
            end
        end
        fault = (mtype == 4'hf);
    endtask

    task automatic check_value(input string sig, input logic [63:0] expv, input logic [63:0] act);
        test_checks++;
        assert (act === expv) else begin
            $display("Error: %0s expected 0x%0h got 0x%0h", sig, expv, act);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic report_bad_line(input int idx);
        $display("vector line %0d could not be parsed", idx + 1);
        test_errs++;
        total_errs++;
    endtask

    task automatic start_test(input logic [8*32-1:0] name);
        test_name   = name;
        test_open   = 1'b1;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %0s: %0d checks, ok", test_name, test_checks);
        end else begin
            tests_failed++;
            $display("test %0s: %0d checks, %0d errors", test_name, test_checks, test_errs);
        end
        test_open = 1'b0;
    endtask

    task automatic load_vectors(output logic ok);
        string line_buf;
        int    fd;
        int    n;
        fd = $fopen(VEC_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line_buf = "";
                n = $fgets(line_buf, fd);
                if (n > 0) begin
                    vec_lines.push_back(line_buf);
                end
            end
            $fclose(fd);
        end
    endtask

    // what the registers should hold after a write, from the privilege and WARL rules
    task automatic update_shadow(input logic [1:0] priv, input logic [11:0] addr,
                                 input logic [31:0] data);
        logic [7:0] cbyte;
        int         base;
        if (priv == 2'd3) begin
            if (addr == 12'hbc0 || addr == 12'hbc1) begin
                base = addr[0] ? 4 : 0;
                for (int b = 0; b < 4; b++) begin
                    cbyte    = 8'(data >> (8 * b));
                    cbyte[7] = 1'b0;
                    if (cbyte[1:0] != 2'd3) begin
                        cbyte[1:0] = 2'd0;
                    end
                    shadow_cfg[base + b] = cbyte;
                end
            end else if (addr >= 12'hbd0 && addr <= 12'hbd7) begin
                shadow_addr[addr[2:0]] = data;
            end
        end
    endtask

    task automatic csr_write(input logic [1:0] priv, input logic [11:0] addr,
                             input logic [31:0] data);
        @(posedge core_clk);
        csr_cur_privilege <= priv;
        csr_wr.we         <= 1'b1;
        csr_wr.addr       <= addr;
        csr_wr.data       <= data;
        @(posedge core_clk);
        csr_wr.we <= 1'b0;
        update_shadow(priv, addr, data);
    endtask

    task automatic csr_read_check(input int port, input logic [11:0] addr, input logic hit,
                                  input logic [31:0] data);
        @(posedge core_clk);
        if (port == 0) begin
            csr_raddr0 <= addr;
        end else begin
            csr_raddr1 <= addr;
        end
        @(negedge core_clk);
        if (port == 0) begin
            check_value("csr_hit0", 64'(hit), 64'(csr_hit0));
            check_value("csr_rdata0", 64'(data), 64'(csr_rdata0));
        end else begin
            check_value("csr_hit1", 64'(hit), 64'(csr_hit1));
            check_value("csr_rdata1", 64'(data), 64'(csr_rdata1));
        end
    endtask

    task automatic request_check(input logic lsu, input pma_pkg::pa_t pa, input logic fault,
                                 input logic [3:0] mtype, input logic namo);
        @(posedge core_clk);
        if (lsu) begin
            lsu_req.valid <= 1'b1;
            lsu_req.pa    <= pa;
        end else begin
            ifu_req.valid <= 1'b1;
            ifu_req.pa    <= pa;
        end
        @(posedge core_clk);
        lsu_req.valid <= 1'b0;
        ifu_req.valid <= 1'b0;
        @(negedge core_clk);
        if (lsu) begin
            check_value("lsu_resp.valid", 64'(1'b1), 64'(lsu_resp.valid));
            check_value("lsu_resp.fault", 64'(fault), 64'(lsu_resp.fault));
            check_value("lsu_resp.mtype", 64'(mtype), 64'(lsu_resp.mtype));
            check_value("lsu_resp.namo", 64'(namo), 64'(lsu_resp.namo));
        end else begin
            check_value("ifu_resp.valid", 64'(1'b1), 64'(ifu_resp.valid));
            check_value("ifu_resp.fault", 64'(fault), 64'(ifu_resp.fault));
            check_value("ifu_resp.mtype", 64'(mtype), 64'(ifu_resp.mtype));
            check_value("ifu_resp.namo", 64'(1'b0), 64'(ifu_resp.namo));
        end
        @(negedge core_clk);
        if (lsu) begin
            check_value("lsu_resp.valid", 64'(1'b0), 64'(lsu_resp.valid));  // single-cycle strobe
        end else begin
            check_value("ifu_resp.valid", 64'(1'b0), 64'(ifu_resp.valid));
        end
    endtask

    task automatic play_vectors();
        logic [7:0]      op;
        int              n;
        int              port;
        logic [1:0]      priv;
        logic [11:0]     caddr;
        logic [31:0]     cdata;
        pma_pkg::pa_t    pa;
        logic            hit;
        logic            fault;
        logic            namo;
        logic [3:0]      mtype;
        logic [8*32-1:0] name;
        foreach (vec_lines[i]) begin
            op = 8'h00;
            n  = $sscanf(vec_lines[i], "%c", op);
            case (op)
                "T": begin
                    name = '0;
                    n    = $sscanf(vec_lines[i], "%c %s", op, name);
                    if (test_open) begin
                        finish_test();
                    end
                    start_test(name);
                    if (n != 2) begin
                        report_bad_line(i);
                    end
                end
                "W": begin
                    n = $sscanf(vec_lines[i], "%c %h %h %h", op, priv, caddr, cdata);
                    if (n == 4) begin
                        csr_write(priv, caddr, cdata);
                    end else begin
                        report_bad_line(i);
                    end
                end
                "R": begin
                    n = $sscanf(vec_lines[i], "%c %d %h %h %h", op, port, caddr, hit, cdata);
                    if (n == 5 && (port == 0 || port == 1)) begin
                        csr_read_check(port, caddr, hit, cdata);
                    end else begin
                        report_bad_line(i);
                    end
                end
                "I": begin
                    n = $sscanf(vec_lines[i], "%c %h %h %h", op, pa, fault, mtype);
                    if (n == 4) begin
                        request_check(1'b0, pa, fault, mtype, 1'b0);
                    end else begin
                        report_bad_line(i);
                    end
                end
                "L": begin
                    n = $sscanf(vec_lines[i], "%c %h %h %h %h", op, pa, fault, mtype, namo);
                    if (n == 5) begin
                        request_check(1'b1, pa, fault, mtype, namo);
                    end else begin
                        report_bad_line(i);
                    end
                end
                "#", " ", "\n": ;
                default: report_bad_line(i);
            endcase
        end
    endtask

    task automatic random_traffic();
        logic [31:0] r0;
        logic [31:0] r1;
        logic        fault;
        logic        namo;
        logic [3:0]  mtype;
        for (int i = 0; i <= RAND_COUNT; i++) begin
            @(posedge core_clk);
            if (i < RAND_COUNT) begin
                r0        = xorshift(rng_state);
                r1        = xorshift(r0);
                rng_state = r1;
                if (r0[0]) begin
                    rand_pa[i] = {r0[31:30], r1};
                end else begin
                    rand_pa[i] = {shadow_addr[r0[3:1]], 2'b00} ^ {20'h0, r1[13:0]};  // near an entry
                end
                lsu_req.valid <= 1'b1;
                lsu_req.pa    <= rand_pa[i];
            end else begin
                lsu_req.valid <= 1'b0;
            end
            @(negedge core_clk);
            if (i == 0) begin
                check_value("lsu_resp.valid", 64'(1'b0), 64'(lsu_resp.valid));
            end else begin
                model_lookup(rand_pa[i - 1], fault, mtype, namo);
                check_value("lsu_resp.valid", 64'(1'b1), 64'(lsu_resp.valid));
                check_value("lsu_resp.fault", 64'(fault), 64'(lsu_resp.fault));
                check_value("lsu_resp.mtype", 64'(mtype), 64'(lsu_resp.mtype));
                check_value("lsu_resp.namo", 64'(namo), 64'(lsu_resp.namo));
            end
        end
        @(posedge core_clk);
        @(negedge core_clk);
        check_value("lsu_resp.valid", 64'(1'b0), 64'(lsu_resp.valid));  // nothing after the last
    endtask

    initial begin
        core_reset        = 1'b1;
        csr_cur_privilege = pma_pkg::PRIV_M;
        csr_wr            = '0;
        csr_raddr0        = '0;
        csr_raddr1        = '0;
        ifu_req           = '0;
        lsu_req           = '0;
        rng_state         = 32'hf08e;
        loaded            = 1'b0;
        test_open         = 1'b0;
        total_errs        = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        for (int i = 0; i < pma_pkg::PMA_ENTRIES; i++) begin
            shadow_cfg[i]  = 8'h00;
            shadow_addr[i] = 32'h0;
        end
        load_vectors(load_ok);
        loaded = 1'b1;
        if (!load_ok) begin
            $display("cannot open the vector file %0s", VEC_FILE);
            $display("Test failed");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge core_clk);
            core_reset <= 1'b0;
            start_test("after_reset");
            @(negedge core_clk);
            check_value("ifu_resp.valid", 64'(1'b0), 64'(ifu_resp.valid));
            check_value("lsu_resp.valid", 64'(1'b0), 64'(lsu_resp.valid));
            play_vectors();
            if (test_open) begin
                finish_test();
            end
            start_test("random_lsu");
            random_traffic();
            finish_test();
            $display("%0d tests passed, %0d tests failed, %0d errors",
                     tests_passed, tests_failed, total_errs);
            if (tests_failed == 0 && total_errs == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/pma_vectors.txt
# op T: test name | W: priv csr data | R: port csr hit data
# op I: pa fault mtype | L: pa fault mtype namo; all values hex except the decimal read port
T reset_defaults
I 080001000 0 0
L 080001000 0 0 1
I 040000000 0 4
L 040000000 0 4 0
I 100000000 0 6
L 100000000 0 6 0
T csr_readback
W 3 bd0 12345678
R 0 bd0 1 12345678
R 1 bd0 1 12345678
W 3 bc0 3f864b99
R 0 bc0 1 3f044b18
R 1 bc0 1 3f044b18
R 1 bc1 1 00000000
R 0 bc2 0 00000000
R 1 bd8 0 00000000
R 0 300 0 00000000
T priv_blocked
W 1 bd0 deadbeef
R 0 bd0 1 12345678
W 0 bc0 ffffffff
R 1 bc0 1 3f044b18
T napot_priority
W 3 bc0 00000000
W 3 bd1 400021ff
W 3 bd2 40001fff
W 3 bc0 003f4b00
R 0 bc0 1 003f4b00
I 100000000 1 f
L 100000000 1 f 0
I 10000fffc 1 f
L 10000fff8 1 f 0
I 100010000 0 6
L 100010000 0 6 0
L 0fffffffc 0 0 1
L 100008000 0 2 1
I 100008abc 0 2
L 100008ffc 0 2 1
L 100009000 1 f 0

//--- pma_unit.f
common/pma_pkg.sv
pma_checker/pma_entry_match.sv
pma_checker/pma_default_map.sv
pma_checker/pma_checker.sv
source/pma_csr.sv
source/pma_unit.sv
sim/pma_unit_tb.sv

//--- Makefile
# Verilator build and run for the PMA unit testbench

TOP := pma_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f pma_unit.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Test passed" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
